// ==== logic/vec_sys_cfg.svh ====
`ifndef VEC_SYS_CFG_SVH
`define VEC_SYS_CFG_SVH

// Vector unit geometry
`define VEC_NR_LANES 4
`define VEC_ELEM_W 32

// Memory side
`define VEC_ADDR_W 32
`define VEC_LINE_BYTES 16

// Byte offset bits inside one line
`define VEC_LINE_OFF_W ($clog2(`VEC_LINE_BYTES))

// Lines remembered by the coherence filter
`define VEC_INVAL_ENTRIES 4

`endif

// ==== logic/vec_sys_pkg.sv ====
`include "vec_sys_cfg.svh"

package vec_sys_pkg;

  ////////////////////
  // Plain vectors
  ////////////////////

  typedef logic [`VEC_ADDR_W-1:0] addr_t;
  typedef logic [`VEC_ADDR_W-`VEC_LINE_OFF_W-1:0] line_addr_t;
  typedef logic [`VEC_ELEM_W-1:0] elem_t;
  // Lane 0 sits in the low bits
  typedef logic [`VEC_NR_LANES*`VEC_ELEM_W-1:0] wide_data_t;
  typedef logic [`VEC_LINE_BYTES-1:0] strb_t;
  typedef logic [$clog2(`VEC_NR_LANES)-1:0] lane_idx_t;

  ////////////////////
  // Enums
  ////////////////////

  typedef enum logic [1:0] {
    VOP_ADD = 2'd0,
    VOP_SUB = 2'd1,
    VOP_MUL = 2'd2,
    VOP_XOR = 2'd3
  } vec_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WRITE
  } ctrl_state_e;

  ////////////////////
  // Requests
  ////////////////////

  typedef struct packed {
    vec_op_e    op;
    addr_t      addr;
    wide_data_t src_a;
    wide_data_t src_b;
  } vec_cmd_t;

  typedef struct packed {
    addr_t addr;
    elem_t wdata;
  } core_req_t;

  typedef struct packed {
    addr_t      addr;
    wide_data_t wdata;
    strb_t      strb;
  } mem_req_t;

endpackage

// ==== logic/vec_dispatch_ctrl.sv ====
`timescale 1ns/100ps

module vec_dispatch_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cmd_valid_i,
  input  vec_sys_pkg::vec_op_e cmd_op_i,
  input  vec_sys_pkg::addr_t   cmd_addr_i,
  input  logic                 vec_wr_done_i,
  output logic                 lane_start_o,
  output vec_sys_pkg::vec_op_e lane_op_o,
  output logic                 vec_wr_valid_o,
  output vec_sys_pkg::addr_t   vec_wr_addr_o,
  output logic                 busy_o,
  output logic                 done_o
);
  import vec_sys_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  vec_op_e     op_q;
  addr_t       addr_q;
  logic        accept;
  logic        done_q;

  assign accept = (state_q == ST_IDLE) && cmd_valid_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          state_d = ST_EXEC;
        end
      end
      // Lanes register their result on the accept edge
      ST_EXEC: begin
        state_d = ST_WRITE;
      end
      ST_WRITE: begin
        if (vec_wr_done_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == ST_WRITE) && vec_wr_done_i;
    end
  end

  // Command fields kept for the whole operation
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q   <= cmd_op_i;
      addr_q <= cmd_addr_i;
    end
  end

  // Live opcode while idle so the lanes see it on the start edge
  assign lane_op_o      = (state_q == ST_IDLE) ? cmd_op_i : op_q;
  assign lane_start_o   = accept;
  assign vec_wr_valid_o = (state_q == ST_WRITE);
  assign vec_wr_addr_o  = addr_q;
  assign busy_o         = (state_q != ST_IDLE);
  assign done_o         = done_q;

  a_no_cmd_when_busy : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> !busy_o
  );

endmodule

// ==== logic/vec_lane_alu.sv ====
`timescale 1ns/100ps

`include "vec_sys_cfg.svh"

module vec_lane_alu (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    start_i,
  input  vec_sys_pkg::vec_op_e    op_i,
  input  vec_sys_pkg::wide_data_t src_a_i,
  input  vec_sys_pkg::wide_data_t src_b_i,
  output vec_sys_pkg::wide_data_t result_o
);
  import vec_sys_pkg::*;

  wide_data_t lane_res;
  wide_data_t result_q;

  // One element of one lane
  function automatic elem_t lane_calc(vec_op_e op, elem_t a, elem_t b);
    elem_t res;
    unique case (op)
      VOP_ADD: begin
        res = a + b;
      end
      VOP_SUB: begin
        res = a - b;
      end
      // low half of the product only
      VOP_MUL: begin
        res = a * b;
      end
      VOP_XOR: begin
        res = a ^ b;
      end
      default: begin
        res = '0;
      end
    endcase
    return res;
  endfunction

  ////////////////////
  // Lanes
  ////////////////////

  always_comb begin
    for (int unsigned l = 0; l < `VEC_NR_LANES; l++) begin
      lane_res[l*`VEC_ELEM_W +: `VEC_ELEM_W] = lane_calc(
        op_i,
        src_a_i[l*`VEC_ELEM_W +: `VEC_ELEM_W],
        src_b_i[l*`VEC_ELEM_W +: `VEC_ELEM_W]
      );
    end
  end

  // Held through any write stall
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q <= '0;
    end else if (start_i) begin
      result_q <= lane_res;
    end
  end

  assign result_o = result_q;

endmodule

// ==== logic/core_store_widener.sv ====
`timescale 1ns/100ps

`include "vec_sys_cfg.svh"

module core_store_widener (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  vec_sys_pkg::core_req_t core_req_i,
  input  logic                   core_valid_i,
  input  logic                   taken_i,
  output vec_sys_pkg::mem_req_t  wide_req_o,
  output logic                   wide_valid_o
);
  import vec_sys_pkg::*;

  core_req_t req_q;
  logic      full_q;
  logic      taken_q;
  logic      capture;
  lane_idx_t lane;

  // Core still shows the old request in its grant cycle
  assign capture = core_valid_i && !full_q && !taken_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q  <= 1'b0;
      taken_q <= 1'b0;
    end else begin
      taken_q <= taken_i;
      if (taken_i) begin
        full_q <= 1'b0;
      end else if (capture) begin
        full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= core_req_i;
    end
  end

  // Word select from address bits 3:2
  assign lane = req_q.addr[$clog2(`VEC_ELEM_W/8) +: $bits(lane_idx_t)];

  always_comb begin
    wide_req_o      = '0;
    wide_req_o.addr = {req_q.addr[`VEC_ADDR_W-1:`VEC_LINE_OFF_W], {`VEC_LINE_OFF_W{1'b0}}};
    wide_req_o.wdata[lane*`VEC_ELEM_W +: `VEC_ELEM_W] = req_q.wdata;
    wide_req_o.strb[lane*(`VEC_ELEM_W/8) +: `VEC_ELEM_W/8] = '1;
  end

  assign wide_valid_o = full_q;

endmodule

// ==== logic/mem_port_arbiter.sv ====
`timescale 1ns/100ps

module mem_port_arbiter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  vec_sys_pkg::mem_req_t   core_req_i,
  input  logic                    core_valid_i,
  input  vec_sys_pkg::addr_t      vec_addr_i,
  input  vec_sys_pkg::wide_data_t vec_data_i,
  input  logic                    vec_valid_i,
  input  logic                    mem_ready_i,
  output vec_sys_pkg::mem_req_t   mem_req_o,
  output logic                    mem_req_valid_o,
  output logic                    core_taken_o,
  output logic                    vec_done_o,
  output logic                    core_gnt_o,
  output logic                    grant_is_vec_o,
  output logic                    grant_fire_o
);

  logic last_vec_q;
  logic lock_q;
  logic lock_vec_q;
  logic sel_vec;
  logic fire;
  logic gnt_q;

  // Round robin, choice frozen while the port stalls
  always_comb begin
    if (lock_q) begin
      sel_vec = lock_vec_q;
    end else if (core_valid_i && vec_valid_i) begin
      sel_vec = !last_vec_q;
    end else begin
      sel_vec = vec_valid_i;
    end
  end

  always_comb begin
    mem_req_o = core_req_i;
    if (sel_vec) begin
      mem_req_o.addr  = vec_addr_i;
      mem_req_o.wdata = vec_data_i;
      mem_req_o.strb  = '1;
    end
  end

  assign mem_req_valid_o = core_valid_i || vec_valid_i;
  assign fire            = mem_req_valid_o && mem_ready_i;
  assign core_taken_o    = fire && !sel_vec;
  assign vec_done_o      = fire && sel_vec;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_vec_q <= 1'b1;  // core first out of reset
      lock_q     <= 1'b0;
      lock_vec_q <= 1'b0;
      gnt_q      <= 1'b0;
    end else begin
      lock_q     <= mem_req_valid_o && !mem_ready_i;
      lock_vec_q <= sel_vec;
      gnt_q      <= core_taken_o;
      if (fire) begin
        last_vec_q <= sel_vec;
      end
    end
  end

  assign core_gnt_o     = gnt_q;
  assign grant_is_vec_o = sel_vec;
  assign grant_fire_o   = fire;

  // Exactly one grant per transfer, and only to a source that requests
  a_grant_exclusive : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    grant_fire_o |-> $onehot({core_taken_o && core_valid_i, vec_done_o && vec_valid_i})
  );

endmodule

// ==== logic/coh_inval_filter.sv ====
`timescale 1ns/100ps

`include "vec_sys_cfg.svh"

module coh_inval_filter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    en_i,
  input  logic                    fire_i,
  input  logic                    fire_is_vec_i,
  input  vec_sys_pkg::addr_t      fire_addr_i,
  output logic                    inval_valid_o,
  output vec_sys_pkg::line_addr_t inval_line_o
);
  import vec_sys_pkg::*;

  line_addr_t                               lines_q [`VEC_INVAL_ENTRIES];
  logic [`VEC_INVAL_ENTRIES-1:0]            valid_q;
  logic [$clog2(`VEC_INVAL_ENTRIES)-1:0]    wr_ptr_q;
  line_addr_t                               fire_line;
  logic                                     hit;
  logic                                     record;
  logic                                     inval_q;
  line_addr_t                               inval_line_q;
  logic                                     inval_line_known;

  assign fire_line = fire_addr_i[`VEC_ADDR_W-1:`VEC_LINE_OFF_W];

  always_comb begin
    hit = 1'b0;
    for (int unsigned e = 0; e < `VEC_INVAL_ENTRIES; e++) begin
      if (valid_q[e] && (lines_q[e] == fire_line)) begin
        hit = 1'b1;
      end
    end
  end

  // New core lines only, oldest entry replaced first
  assign record = fire_i && !fire_is_vec_i && !hit;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      inval_q  <= 1'b0;
    end else begin
      inval_q <= fire_i && fire_is_vec_i && en_i && hit;
      if (record) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q <= (wr_ptr_q == `VEC_INVAL_ENTRIES - 1) ? '0 : wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (record) begin
      lines_q[wr_ptr_q] <= fire_line;
    end
    if (fire_i && fire_is_vec_i) begin
      inval_line_q <= fire_line;
    end
  end

  assign inval_valid_o = inval_q;
  assign inval_line_o  = inval_line_q;

  // Reported line is still held in the table
  always_comb begin
    inval_line_known = 1'b0;
    for (int unsigned e = 0; e < `VEC_INVAL_ENTRIES; e++) begin
      if (valid_q[e] && (lines_q[e] == inval_line_q)) begin
        inval_line_known = 1'b1;
      end
    end
  end

  a_inval_after_vec : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    inval_valid_o |-> $past(fire_i && fire_is_vec_i && en_i) && inval_line_known
  );

endmodule

// ==== logic/vec_system.sv ====
`timescale 1ns/100ps

module vec_system (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Vector commands
  input  logic                    cmd_valid_i,
  input  vec_sys_pkg::vec_cmd_t   cmd_i,
  output logic                    busy_o,
  output logic                    done_o,
  // Core stores
  input  logic                    core_req_valid_i,
  input  vec_sys_pkg::core_req_t  core_req_i,
  output logic                    core_gnt_o,
  // Shared memory port
  output logic                    mem_req_valid_o,
  output vec_sys_pkg::mem_req_t   mem_req_o,
  input  logic                    mem_ready_i,
  // Coherence
  input  logic                    coh_en_i,
  output logic                    inval_valid_o,
  output vec_sys_pkg::line_addr_t inval_line_o
);
  import vec_sys_pkg::*;

  logic       lane_start;
  vec_op_e    lane_op;
  logic       vec_wr_valid;
  addr_t      vec_wr_addr;
  logic       vec_wr_done;
  wide_data_t alu_result;
  mem_req_t   wide_req;
  logic       wide_valid;
  logic       core_taken;
  logic       grant_is_vec;
  logic       grant_fire;

  ////////////////////
  // Vector side
  ////////////////////

  vec_dispatch_ctrl i_ctrl (
    .clk_i          (clk_i       ),
    .arst_n_i       (arst_n_i    ),
    .cmd_valid_i    (cmd_valid_i ),
    .cmd_op_i       (cmd_i.op    ),
    .cmd_addr_i     (cmd_i.addr  ),
    .vec_wr_done_i  (vec_wr_done ),
    .lane_start_o   (lane_start  ),
    .lane_op_o      (lane_op     ),
    .vec_wr_valid_o (vec_wr_valid),
    .vec_wr_addr_o  (vec_wr_addr ),
    .busy_o         (busy_o      ),
    .done_o         (done_o      )
  );

  vec_lane_alu i_lanes (
    .clk_i    (clk_i      ),
    .arst_n_i (arst_n_i   ),
    .start_i  (lane_start ),
    .op_i     (lane_op    ),
    .src_a_i  (cmd_i.src_a),
    .src_b_i  (cmd_i.src_b),
    .result_o (alu_result )
  );

  ////////////////////
  // Memory side
  ////////////////////

  core_store_widener i_widener (
    .clk_i        (clk_i           ),
    .arst_n_i     (arst_n_i        ),
    .core_req_i   (core_req_i      ),
    .core_valid_i (core_req_valid_i),
    .taken_i      (core_taken      ),
    .wide_req_o   (wide_req        ),
    .wide_valid_o (wide_valid      )
  );

  mem_port_arbiter i_arbiter (
    .clk_i           (clk_i          ),
    .arst_n_i        (arst_n_i       ),
    .core_req_i      (wide_req       ),
    .core_valid_i    (wide_valid     ),
    .vec_addr_i      (vec_wr_addr    ),
    .vec_data_i      (alu_result     ),
    .vec_valid_i     (vec_wr_valid   ),
    .mem_ready_i     (mem_ready_i    ),
    .mem_req_o       (mem_req_o      ),
    .mem_req_valid_o (mem_req_valid_o),
    .core_taken_o    (core_taken     ),
    .vec_done_o      (vec_wr_done    ),
    .core_gnt_o      (core_gnt_o     ),
    .grant_is_vec_o  (grant_is_vec   ),
    .grant_fire_o    (grant_fire     )
  );

  coh_inval_filter i_inval_filter (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .en_i          (coh_en_i      ),
    .fire_i        (grant_fire    ),
    .fire_is_vec_i (grant_is_vec  ),
    .fire_addr_i   (mem_req_o.addr),
    .inval_valid_o (inval_valid_o ),
    .inval_line_o  (inval_line_o  )
  );

endmodule

// ==== verification/tb_vec_system.sv ====
`timescale 1ns/100ps

`include "vec_sys_cfg.svh"

module tb_vec_system;
  import vec_sys_pkg::*;

  localparam int          NR_ROWS        = 10;
  localparam int          TIMEOUT_CYCLES = NR_ROWS * 64;
  localparam logic [31:0] SEED           = 32'heb04;

  typedef enum logic [1:0] {
    K_CORE,
    K_VEC,
    K_BOTH
  } kind_e;

  typedef struct packed {
    kind_e      kind;
    vec_op_e    op;
    addr_t      vaddr;
    wide_data_t src_a;
    wide_data_t src_b;
    addr_t      caddr;
    elem_t      cdata;
    logic       coh_en;
    logic       exp_inval;
  } row_t;

  logic       clk_i;
  logic       arst_n_i;
  logic       cmd_valid_i;
  vec_cmd_t   cmd_i;
  logic       busy_o;
  logic       done_o;
  logic       core_req_valid_i;
  core_req_t  core_req_i;
  logic       core_gnt_o;
  logic       mem_req_valid_o;
  mem_req_t   mem_req_o;
  logic       mem_ready_i;
  logic       coh_en_i;
  logic       inval_valid_o;
  line_addr_t inval_line_o;

  row_t        rows [NR_ROWS];
  string       names [NR_ROWS];
  mem_req_t    xfer_q [$];
  line_addr_t  inval_q [$];
  int          done_cnt;
  int          gnt_cnt;
  int          cycle_cnt;
  logic        last_was_vec;
  logic        busy_prev;
  logic        hold_pend;
  mem_req_t    hold_req;
  int unsigned seed_val;

  vec_system dut_i (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .cmd_valid_i      (cmd_valid_i     ),
    .cmd_i            (cmd_i           ),
    .busy_o           (busy_o          ),
    .done_o           (done_o          ),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i      ),
    .core_gnt_o       (core_gnt_o      ),
    .mem_req_valid_o  (mem_req_valid_o ),
    .mem_req_o        (mem_req_o       ),
    .mem_ready_i      (mem_ready_i     ),
    .coh_en_i         (coh_en_i        ),
    .inval_valid_o    (inval_valid_o   ),
    .inval_line_o     (inval_line_o    )
  );

  always #2 clk_i = ~clk_i;

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_line(string name, line_addr_t exp, line_addr_t act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
      abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic wide_data_t lanes_expect(vec_op_e op, wide_data_t a, wide_data_t b);
    wide_data_t  res;
    elem_t       ea;
    elem_t       eb;
    logic [63:0] prod;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      ea   = a[l*`VEC_ELEM_W +: `VEC_ELEM_W];
      eb   = b[l*`VEC_ELEM_W +: `VEC_ELEM_W];
      prod = {32'h0, ea} * {32'h0, eb};
      case (op)
        VOP_ADD: res[l*`VEC_ELEM_W +: `VEC_ELEM_W] = ea + eb;
        VOP_SUB: res[l*`VEC_ELEM_W +: `VEC_ELEM_W] = ea - eb;
        VOP_MUL: res[l*`VEC_ELEM_W +: `VEC_ELEM_W] = prod[31:0];
        default: res[l*`VEC_ELEM_W +: `VEC_ELEM_W] = ea ^ eb;
      endcase
    end
    return res;
  endfunction

  function automatic mem_req_t vec_word(row_t r);
    mem_req_t w;
    w.addr  = r.vaddr;
    w.wdata = lanes_expect(r.op, r.src_a, r.src_b);
    w.strb  = '1;
    return w;
  endfunction

  // Word lands in lane addr[3:2] of a line-aligned word
  function automatic mem_req_t core_word(row_t r);
    mem_req_t w;
    int       lane;
    lane    = r.caddr[3:2];
    w       = '0;
    w.addr  = {r.caddr[`VEC_ADDR_W-1:4], 4'h0};
    w.wdata[lane*`VEC_ELEM_W +: `VEC_ELEM_W] = r.cdata;
    w.strb[lane*4 +: 4] = 4'hF;
    return w;
  endfunction

  ////////////////////
  // Monitor
  ////////////////////

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (mem_req_valid_o && mem_ready_i) begin
        xfer_q.push_back(mem_req_o);
      end
      if (inval_valid_o) begin
        inval_q.push_back(inval_line_o);
      end
      if (done_o) begin
        done_cnt++;
      end
      if (core_gnt_o) begin
        gnt_cnt++;
      end
      if (hold_pend) begin
        if (!mem_req_valid_o) begin
          abort_run("Memory request was withdrawn during a stall");
        end
        check_mem_req("stall_hold", hold_req, mem_req_o);
      end
      hold_pend = mem_req_valid_o && !mem_ready_i;
      hold_req  = mem_req_o;
      if (busy_prev && !busy_o && !done_o) begin
        abort_run("busy_o fell without a done_o pulse");
      end
      if (done_o && (busy_o || !busy_prev)) begin
        abort_run("done_o did not close a busy period");
      end
      busy_prev = busy_o;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("The run timed out after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Random stalls on the memory port
  task automatic tick();
    @(posedge clk_i);
    mem_ready_i <= (($urandom % 4) != 0);
  endtask

  task automatic set_row(int idx, string name, kind_e kind, vec_op_e op, addr_t vaddr,
                         wide_data_t a, wide_data_t b, addr_t caddr, elem_t cdata,
                         logic coh, logic inv);
    names[idx] = name;
    rows[idx]  = {kind, op, vaddr, a, b, caddr, cdata, coh, inv};
  endtask

  task automatic load_table();
    set_row(0, "core_lane0", K_CORE, VOP_ADD, 32'h0, '0, '0, 32'h100, 32'h1111_1111, 1, 0);
    set_row(1, "core_lane3", K_CORE, VOP_ADD, 32'h0, '0, '0, 32'h20C, 32'hA5A5_0F0F, 1, 0);
    set_row(2, "vec_add_miss", K_VEC, VOP_ADD, 32'h300,
            {32'h4, 32'h3, 32'h2, 32'hFFFF_FFFF}, {32'h10, 32'h20, 32'h30, 32'h1},
            32'h0, 32'h0, 1, 0);
    set_row(3, "vec_sub_hit", K_VEC, VOP_SUB, 32'h100,
            {32'h0, 32'h100, 32'h8000_0000, 32'h5}, {32'h1, 32'h1, 32'h1, 32'h7},
            32'h0, 32'h0, 1, 1);
    set_row(4, "vec_mul_coh_off", K_VEC, VOP_MUL, 32'h200,
            {32'h0001_0000, 32'h7, 32'hFFFF_FFFF, 32'h1234},
            {32'h0001_0000, 32'h9, 32'h2, 32'h10}, 32'h0, 32'h0, 0, 0);
    set_row(5, "both_core_first", K_BOTH, VOP_XOR, 32'h500,
            {32'hFFFF_0000, 32'h1234_5678, 32'h0, 32'hAAAA_AAAA},
            {32'h00FF_FF00, 32'h1234_5678, 32'h1, 32'h5555_5555},
            32'h408, 32'hDEAD_BEEF, 1, 0);
    set_row(6, "core_lane1", K_CORE, VOP_ADD, 32'h0, '0, '0, 32'h604, 32'h0BAD_F00D, 1, 0);
    set_row(7, "both_vec_first", K_BOTH, VOP_ADD, 32'h400,
            {32'h1, 32'h2, 32'h3, 32'h4}, {32'h10, 32'h20, 32'h30, 32'h40},
            32'h708, 32'h7777_0001, 1, 1);
    set_row(8, "vec_evicted_miss", K_VEC, VOP_XOR, 32'h100,
            {32'hF0F0_F0F0, 32'h0, 32'h1, 32'h2}, {32'h0F0F_0F0F, 32'h0, 32'h3, 32'h2},
            32'h0, 32'h0, 1, 0);
    set_row(9, "vec_recent_hit", K_VEC, VOP_SUB, 32'h700,
            {32'h9, 32'h8, 32'h7, 32'h6}, {32'h1, 32'h2, 32'h3, 32'h4},
            32'h0, 32'h0, 1, 1);
  endtask

  task automatic run_row(int idx);
    row_t     r;
    mem_req_t exp_q [$];
    logic     core_ok;
    logic     vec_ok;
    r = rows[idx];
    xfer_q.delete();
    inval_q.delete();
    done_cnt = 0;
    gnt_cnt  = 0;
    core_ok  = (r.kind == K_VEC);
    vec_ok   = (r.kind == K_CORE);
    coh_en_i <= r.coh_en;
    if (r.kind != K_CORE) begin
      cmd_valid_i <= 1'b1;
      cmd_i       <= {r.op, r.vaddr, r.src_a, r.src_b};
      tick();
      cmd_valid_i <= 1'b0;
    end
    // Core store one edge later so both sources become pending together
    if (r.kind != K_VEC) begin
      core_req_valid_i <= 1'b1;
      core_req_i       <= {r.caddr, r.cdata};
    end
    while (!(core_ok && vec_ok)) begin
      tick();
      if (core_gnt_o) begin
        core_req_valid_i <= 1'b0;
        core_ok = 1'b1;
      end
      if (done_o) begin
        vec_ok = 1'b1;
      end
    end
    repeat (4) tick();

    case (r.kind)
      K_CORE: exp_q.push_back(core_word(r));
      K_VEC:  exp_q.push_back(vec_word(r));
      default: begin
        if (last_was_vec) begin
          exp_q.push_back(core_word(r));
          exp_q.push_back(vec_word(r));
        end else begin
          exp_q.push_back(vec_word(r));
          exp_q.push_back(core_word(r));
        end
      end
    endcase
    if (r.kind != K_BOTH) begin
      last_was_vec = (r.kind == K_VEC);
    end

    check_count({names[idx], "_transfers"}, exp_q.size(), xfer_q.size());
    for (int i = 0; i < exp_q.size(); i++) begin
      check_mem_req($sformatf("%s_word%0d", names[idx], i), exp_q[i], xfer_q[i]);
    end
    check_count({names[idx], "_done"}, (r.kind != K_CORE), done_cnt);
    check_count({names[idx], "_gnt"}, (r.kind != K_VEC), gnt_cnt);
    check_count({names[idx], "_invals"}, r.exp_inval, inval_q.size());
    if (r.exp_inval) begin
      check_line({names[idx], "_inval_line"}, r.vaddr[`VEC_ADDR_W-1:4], inval_q[0]);
    end
  endtask

  initial begin
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_i            = '0;
    core_req_valid_i = 1'b0;
    core_req_i       = '0;
    mem_ready_i      = 1'b0;
    coh_en_i         = 1'b0;
    done_cnt         = 0;
    gnt_cnt          = 0;
    cycle_cnt        = 0;
    busy_prev        = 1'b0;
    hold_pend        = 1'b0;
    hold_req         = '0;
    // Core wins the first tie after reset
    last_was_vec     = 1'b1;
    seed_val         = $urandom(SEED);
    load_table();

    repeat (10) tick();
    arst_n_i <= 1'b1;
    repeat (2) tick();

    for (int i = 0; i < NR_ROWS; i++) begin
      run_row(i);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/vec_sys_pkg.sv
logic/vec_dispatch_ctrl.sv
logic/vec_lane_alu.sv
logic/core_store_widener.sv
logic/mem_port_arbiter.sv
logic/coh_inval_filter.sv
logic/vec_system.sv
verification/tb_vec_system.sv

// ==== Bender.yml ====
package:
  name: vec_system

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vec_sys_pkg.sv
      - logic/vec_dispatch_ctrl.sv
      - logic/vec_lane_alu.sv
      - logic/core_store_widener.sv
      - logic/mem_port_arbiter.sv
      - logic/coh_inval_filter.sv
      - logic/vec_system.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_vec_system.sv
